/* logic/keypad_consts.svh */
`ifndef KEYPAD_CONSTS_SVH
`define KEYPAD_CONSTS_SVH

// Keypad scan timing

`define KP_SCAN_CYCLES 50000     // Clocks per column step, 1 ms at 50 MHz

`define KP_DEBOUNCE_SWEEPS 3     // Matching sweeps for press or release

// Serial link

`define KP_BAUD_CYCLES 434       // Clocks per bit, 115200 baud at 50 MHz

// Byte queue

`define KP_FIFO_DEPTH 4          // Entries between scanner and transmitter

`endif

/* logic/keypad_pkg.sv */
package keypad_pkg;

    // Debounce machine, advanced once per full sweep
    typedef enum logic [1:0] {
        SCAN_IDLE         = 2'd0,    // No key, waiting for a candidate
        SCAN_PRESS_WAIT   = 2'd1,    // Same key must repeat
        SCAN_HELD         = 2'd2,    // Strobe sent, key still down
        SCAN_RELEASE_WAIT = 2'd3     // Counting empty sweeps
    } scan_state_t;

    // Key number, row * 4 + column
    typedef logic [3:0] key_code_t;

endpackage

/* logic/uart_pkg.sv */
package uart_pkg;

    // Transmitter frame phases
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,    // Line high, waiting for a byte
        TX_START = 2'd1,    // Start bit, line low
        TX_DATA  = 2'd2,    // Eight data bits, LSB first
        TX_STOP  = 2'd3     // Stop bit, line high
    } tx_state_t;

    typedef logic [7:0] byte_t;

endpackage

/* logic/byte_link_if.sv */
interface byte_link_if;
    import uart_pkg::*;

    byte_t rd_data;    // Head of the queue
    logic  empty;      // Nothing queued
    logic  rd_en;      // Pop strobe from the transmitter
    logic  busy;       // Frame in flight

    modport producer (
        output rd_data,
        output empty,
        input  rd_en,
        input  busy
    );

    modport consumer (
        input  rd_data,
        input  empty,
        output rd_en,
        output busy
    );

endinterface

/* logic/keypad_scanner.sv */
`include "keypad_consts.svh"

module keypad_scanner #(
    parameter int scan_cycles = `KP_SCAN_CYCLES
) (
    input  logic            sys_clk,
    input  logic            rst_n,
    input  logic [3:0]      row,
    output logic [3:0]      col,
    output logic            key_valid,
    output uart_pkg::byte_t key_byte
);
    import keypad_pkg::*;

    localparam int CNT_W = (scan_cycles > 1) ? $clog2(scan_cycles) : 1;
    localparam int DEB   = `KP_DEBOUNCE_SWEEPS;
    localparam int DEB_W = $clog2(DEB + 1);

    logic [CNT_W-1:0] scan_cnt;
    logic [1:0]       col_idx;
    logic             step_end;     // Last cycle of a column step
    logic             sweep_end;    // Last cycle of column 3

    logic [3:0]       row_s1;
    logic [3:0]       row_s2;

    logic [2:0]       low_cnt;      // Rows low in the current step
    logic [1:0]       low_row;      // Lowest numbered low row
    logic [1:0]       sweep_hits;   // Keys seen so far, saturates at 2
    logic [1:0]       hits_next;
    key_code_t        sweep_code;   // First key seen in this sweep
    key_code_t        code_next;
    logic             one_key;
    logic             no_key;

    scan_state_t      state;
    logic [DEB_W-1:0] deb_cnt;
    key_code_t        key_code;     // Candidate under debounce

    // Column rotation
    assign step_end  = (scan_cnt == CNT_W'(scan_cycles - 1));
    assign sweep_end = step_end && (col_idx == 2'd3);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            col_idx  <= 2'd0;
        end else if (step_end) begin
            scan_cnt <= '0;
            col_idx  <= col_idx + 2'd1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign col = ~(4'b0001 << col_idx);    // One column driven low

    // Rows come from switches, so bring them into the clock domain
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            row_s1 <= 4'hf;
            row_s2 <= 4'hf;
        end else begin
            row_s1 <= row;
            row_s2 <= row_s1;
        end
    end

    // Evaluate the settled rows at the end of each column step
    always_comb begin
        low_cnt = 3'($countones(~row_s2));
        low_row = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (!row_s2[i]) begin
                low_row = 2'(i);
            end
        end
        hits_next = sweep_hits;
        code_next = sweep_code;
        if (low_cnt != 3'd0) begin
            if (sweep_hits == 2'd0) begin
                code_next = {low_row, col_idx};
            end
            if (low_cnt > 3'd1 || sweep_hits != 2'd0) begin
                hits_next = 2'd2;
            end else begin
                hits_next = 2'd1;
            end
        end
    end

    assign one_key = (hits_next == 2'd1);
    assign no_key  = (hits_next == 2'd0);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            sweep_hits <= 2'd0;
        end else if (step_end) begin
            sweep_hits <= sweep_end ? 2'd0 : hits_next;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (step_end) begin
            sweep_code <= code_next;
        end
    end

    // Debounce, one decision per sweep
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state     <= SCAN_IDLE;
            deb_cnt   <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (sweep_end) begin
                case (state)
                    SCAN_IDLE: begin
                        if (one_key) begin
                            deb_cnt <= DEB_W'(1);
                            state   <= SCAN_PRESS_WAIT;
                        end
                    end
                    SCAN_PRESS_WAIT: begin
                        if (one_key && code_next == key_code) begin
                            if (deb_cnt == DEB_W'(DEB - 1)) begin
                                key_valid <= 1'b1;
                                state     <= SCAN_HELD;
                            end else begin
                                deb_cnt <= deb_cnt + 1'b1;
                            end
                        end else if (one_key) begin
                            deb_cnt <= DEB_W'(1);    // Different key, start over
                        end else begin
                            state <= SCAN_IDLE;
                        end
                    end
                    SCAN_HELD: begin
                        if (no_key) begin
                            deb_cnt <= DEB_W'(1);
                            state   <= SCAN_RELEASE_WAIT;
                        end
                    end
                    SCAN_RELEASE_WAIT: begin
                        if (!no_key) begin
                            state <= SCAN_HELD;    // Bounce, still held
                        end else if (deb_cnt == DEB_W'(DEB - 1)) begin
                            state <= SCAN_IDLE;
                        end else begin
                            deb_cnt <= deb_cnt + 1'b1;
                        end
                    end
                    default: state <= SCAN_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sweep_end && one_key && (state == SCAN_IDLE || state == SCAN_PRESS_WAIT)) begin
            key_code <= code_next;
        end
    end

    assign key_byte = {key_code, key_code};    // Code in both nibbles

    a_one_col_low: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $onehot(~col));

endmodule

/* logic/key_fifo.sv */
`include "keypad_consts.svh"

module key_fifo (
    input  logic            sys_clk,
    input  logic            rst_n,
    input  logic            wr_en,
    input  uart_pkg::byte_t wr_data,
    byte_link_if.producer   link
);
    import uart_pkg::*;

    localparam int DEPTH = `KP_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;

    byte_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign do_wr = wr_en && !full;          // Newest byte lost on overflow
    assign do_rd = link.rd_en && !link.empty;

    assign link.empty   = (count == '0);
    assign link.rd_data = mem[rd_ptr];      // Head visible without a read cycle

    always_ff @(posedge sys_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_pop_empty: assert property (@(posedge sys_clk) disable iff (!rst_n)
        link.rd_en |-> !link.empty);

    // The transmitter holds off further pops while a frame goes out
    a_pop_then_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
        link.rd_en |=> link.busy && !link.rd_en);

endmodule

/* logic/uart_tx.sv */
`include "keypad_consts.svh"

module uart_tx #(
    parameter int baud_cycles = `KP_BAUD_CYCLES
) (
    input  logic          sys_clk,
    input  logic          rst_n,
    byte_link_if.consumer link,
    output logic          txd
);
    import uart_pkg::*;

    localparam int BAUD_W = (baud_cycles > 1) ? $clog2(baud_cycles) : 1;

    tx_state_t         state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_idx;     // Data bit being sent
    byte_t             shift_q;
    logic              bit_end;     // Last clock of the current bit
    logic              pull;        // Take the head byte

    assign bit_end = (baud_cnt == BAUD_W'(baud_cycles - 1));
    assign pull    = (state == TX_IDLE) && !link.empty;

    assign link.rd_en = pull;
    assign link.busy  = (state != TX_IDLE) || pull;

    // Baud counter, parked at zero between frames
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            baud_cnt <= '0;
        end else if (state == TX_IDLE || bit_end) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bit_idx <= 3'd0;
            txd     <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (pull) begin
                        txd   <= 1'b0;    // Start bit
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        txd     <= shift_q[0];
                        bit_idx <= 3'd0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1;    // Stop bit
                            state <= TX_STOP;
                        end else begin
                            txd     <= shift_q[0];
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Next data bit always sits in bit 0
    always_ff @(posedge sys_clk) begin
        if (pull) begin
            shift_q <= link.rd_data;
        end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    a_idle_high: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (state == TX_IDLE) |-> txd);

endmodule

/* logic/keypad_uart_top.sv */
`include "keypad_consts.svh"

module keypad_uart_top #(
    parameter int scan_cycles = `KP_SCAN_CYCLES,
    parameter int baud_cycles = `KP_BAUD_CYCLES
) (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic [3:0] row,
    output logic [3:0] col,
    output logic       txd
);
    import uart_pkg::*;

    logic  key_valid;    // One strobe per debounced press
    byte_t key_byte;

    byte_link_if link_i ();

    keypad_scanner #(
        .scan_cycles (scan_cycles)
    ) scanner_i (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .row       (row),
        .col       (col),
        .key_valid (key_valid),
        .key_byte  (key_byte)
    );

    // No back-pressure to the scanner, a full queue drops the byte
    key_fifo fifo_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .wr_en   (key_valid),
        .wr_data (key_byte),
        .link    (link_i.producer)
    );

    uart_tx #(
        .baud_cycles (baud_cycles)
    ) tx_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .link    (link_i.consumer),
        .txd     (txd)
    );

endmodule

/* test/keypad_model.sv */
module keypad_model (
    input  logic [3:0] col,
    input  logic [4:0] key,    // 0 to 15 pressed, 16 all released
    output logic [3:0] row
);
    logic [1:0] key_row;
    logic [1:0] key_col;

    assign key_row = key[3:2];    // Key number is row * 4 + column
    assign key_col = key[1:0];

    // A closed switch pulls its row down while its column is driven low
    always_comb begin
        row = 4'hf;
        if (!key[4] && !col[key_col]) begin
            row[key_row] = 1'b0;
        end
    end

endmodule

/* test/tb_keypad_uart.sv */
module tb_keypad_uart;
    import uart_pkg::*;

    localparam int SCAN  = 5;
    localparam int BAUD  = 10;
    localparam int SWEEP = 4 * SCAN;    // Clocks per full column sweep

    logic       sys_clk;
    logic       rst_n;
    logic [3:0] row;
    logic [3:0] col;
    logic       txd;
    logic [4:0] key_sel;
    int         errors;
    int         tests_run;
    int         tests_failed;

    keypad_uart_top #(.scan_cycles(SCAN), .baud_cycles(BAUD)) dut_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .row     (row),
        .col     (col),
        .txd     (txd)
    );

    keypad_model keypad_i (.col(col), .key(key_sel), .row(row));

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic set_key(input int k);
        @(posedge sys_clk);
        key_sel <= 5'(k);
    endtask

    // Long enough for three empty sweeps after a partial one
    task automatic release_all();
        set_key(16);
        repeat (5 * SWEEP) @(posedge sys_clk);
    endtask

    // Four sweeps each way, just past the debounce for press and release
    task automatic tap_key(input int k);
        set_key(k);
        repeat (4 * SWEEP) @(posedge sys_clk);
        set_key(16);
        repeat (4 * SWEEP) @(posedge sys_clk);
    endtask

    // Frame decoder, samples mid-bit on falling clock edges
    task automatic recv_frame(input int timeout, output byte_t data, output bit got);
        int waited;
        waited = 0;
        got    = 1'b0;
        data   = '0;
        while (!got && waited < timeout) begin
            @(negedge sys_clk);
            waited++;
            got = (txd === 1'b0);
        end
        if (got) begin
            repeat (BAUD / 2) @(negedge sys_clk);
            compare("start bit", 32'd0, 32'(txd));
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD) @(negedge sys_clk);
                data[i] = txd;    // LSB first
            end
            repeat (BAUD) @(negedge sys_clk);
            compare("stop bit", 32'd1, 32'(txd));
        end
    endtask

    task automatic expect_frame(input string name, input byte_t expected, input int timeout);
        byte_t data;
        bit    got;
        recv_frame(timeout, data, got);
        if (!got) begin
            $display("%s: no frame started within %0d cycles", name, timeout);
            errors++;
        end else begin
            compare(name, 32'(expected), 32'(data));
        end
    endtask

    task automatic expect_no_frame(input string name, input int cycles);
        byte_t data;
        bit    got;
        recv_frame(cycles, data, got);
        compare(name, 32'd0, 32'(got));
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic idle_after_reset();
        int start;
        int low_seen;
        start    = errors;
        low_seen = 0;
        @(negedge sys_clk);
        compare("idle col", 32'h0000_000e, 32'(col));
        repeat (10 * SWEEP) begin
            @(negedge sys_clk);
            if (txd !== 1'b1) low_seen++;
        end
        compare("idle txd low cycles", 32'd0, 32'(low_seen));
        close_test("idle_after_reset", start);
    endtask

    task automatic single_key_frame();
        int start;
        start = errors;
        set_key(1);
        expect_frame("key 1 frame", 8'h11, 20 * SWEEP);
        expect_no_frame("key 1 repeat", 10 * SWEEP);
        release_all();
        close_test("single_key_frame", start);
    endtask

    task automatic all_keys_random();
        int         order [16];
        int         j;
        int         tmp;
        int         start;
        logic [3:0] kc;
        start = errors;
        for (int i = 0; i < 16; i++) order[i] = i;
        for (int i = 15; i > 0; i--) begin    // Fisher-Yates shuffle
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 16; i++) begin
            kc = 4'(order[i]);
            set_key(order[i]);
            expect_frame($sformatf("key %0d frame", order[i]), {kc, kc}, 20 * SWEEP);
            release_all();
        end
        close_test("all_keys_random", start);
    endtask

    task automatic long_hold_once();
        int start;
        start = errors;
        set_key(7);
        expect_frame("hold first frame", 8'h77, 20 * SWEEP);
        expect_no_frame("hold no repeat", 30 * SWEEP);
        release_all();
        set_key(7);
        expect_frame("hold second frame", 8'h77, 20 * SWEEP);
        release_all();
        close_test("long_hold_once", start);
    endtask

    // Press starts in the column 0 step, so column 1 is sampled exactly once
    task automatic short_press_ignored();
        int start;
        int waited;
        start  = errors;
        waited = 0;
        @(negedge sys_clk);
        while (col !== 4'b1110 && waited < SWEEP) begin
            @(negedge sys_clk);
            waited++;
        end
        if (col !== 4'b1110) begin
            $display("short press: column 0 was never driven");
            errors++;
        end
        set_key(9);
        repeat (SWEEP / 2) @(posedge sys_clk);
        set_key(16);
        expect_no_frame("short press", 20 * SWEEP);
        close_test("short_press_ignored", start);
    endtask

    // The second press lands while the first frame is still on the line
    task automatic burst_in_order();
        byte_t got_q [$];
        byte_t exp_q [$];
        byte_t data;
        bit    got;
        int    start;
        int    waited;
        start  = errors;
        waited = 0;
        exp_q  = '{8'hee, 8'h22, 8'h33, 8'h44};
        fork
            begin
                set_key(14);
                while (txd !== 1'b0 && waited < 20 * SWEEP) begin
                    @(negedge sys_clk);
                    waited++;
                end
                if (txd !== 1'b0) begin
                    $display("burst: first frame did not start in time");
                    errors++;
                end
                set_key(16);
                repeat (4 * SWEEP) @(posedge sys_clk);
                tap_key(2);
                tap_key(3);
                tap_key(4);
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    recv_frame(30 * SWEEP, data, got);
                    if (got) begin
                        got_q.push_back(data);
                    end else begin
                        $display("burst: frame %0d did not start in time", i);
                        errors++;
                    end
                end
            end
        join
        compare("burst frame count", 32'd4, 32'(got_q.size()));
        for (int i = 0; i < got_q.size() && i < 4; i++) begin
            compare($sformatf("burst frame %0d", i), 32'(exp_q[i]), 32'(got_q[i]));
        end
        close_test("burst_in_order", start);
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        key_sel      = 5'd16;
        void'($urandom(32'heca1_3852));
        repeat (16) @(posedge sys_clk);
        rst_n <= 1'b1;
        idle_after_reset();
        single_key_frame();
        all_keys_random();
        long_hold_once();
        short_press_ignored();
        burst_in_order();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
logic/keypad_pkg.sv
logic/uart_pkg.sv
logic/byte_link_if.sv
logic/keypad_scanner.sv
logic/key_fifo.sv
logic/uart_tx.sv
logic/keypad_uart_top.sv
test/keypad_model.sv
test/tb_keypad_uart.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_keypad_uart
FILELIST  = build.f
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
